// ==== verilog.f ====
hdl/hart_pkg.sv
hdl/pipe_control.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/hart.sv
verification/hart_props.sv
verification/tb_hart.sv

// ==== Makefile ====
TOP = tb_hart
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# the log decides the result, since the simulator exit code is lost in the pipe
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verification/tb_hart.sv ====
`timescale 1ns/100ps

module tb_hart;
  import hart_pkg::*;

  localparam int MEM_WORDS    = 256; // both memory models decode address bits [9:2]
  localparam int HALT_TIMEOUT = 500; // cycles allowed for one program to reach ebreak

  logic      clk = 1'b0;
  logic      rst = 1'b1;
  word_t     imem_raddr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic      dmem_ren, dmem_wen, retire_valid, retire_halt;
  word_t     retire_inst, retire_pc, retire_rd_wdata;
  reg_addr_t retire_rd_waddr;

  word_t     imem [MEM_WORDS];
  word_t     dmem [MEM_WORDS];
  word_t     lcg_state;

  // program image and the retire sequence it is expected to produce
  word_t     prog [$];
  word_t     exp_pc [$];
  word_t     exp_inst [$];
  word_t     exp_wdata [$];
  reg_addr_t exp_waddr [$];
  bit        exp_has_data [$];      // cleared where the written value is not defined
  word_t     store_addr_q [$];      // every store the data model has taken
  word_t     store_data_q [$];
  word_t     load_addr_q [$];       // every read the data model has answered

  hart i_dut (
    .i_clk(clk), .i_rst(rst),
    .o_imem_raddr(imem_raddr), .i_imem_rdata(imem_rdata),
    .o_dmem_addr(dmem_addr), .o_dmem_wdata(dmem_wdata),
    .o_dmem_ren(dmem_ren), .o_dmem_wen(dmem_wen), .i_dmem_rdata(dmem_rdata),
    .o_retire_valid(retire_valid), .o_retire_halt(retire_halt),
    .o_retire_inst(retire_inst), .o_retire_pc(retire_pc),
    .o_retire_rd_wdata(retire_rd_wdata), .o_retire_rd_waddr(retire_rd_waddr)
  );

  always #5 clk = ~clk;

  // both memories answer in the same cycle
  assign imem_rdata = imem[imem_raddr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // data model is refilled while the hart sits in reset
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] <= fill_word(i);
      end
      store_addr_q.delete();
      store_data_q.delete();
      load_addr_q.delete();
    end else begin
      if (dmem_wen) begin
        dmem[dmem_addr[9:2]] <= dmem_wdata;
        store_addr_q.push_back(dmem_addr);
        store_data_q.push_back(dmem_wdata);
      end
      if (dmem_ren) load_addr_q.push_back(dmem_addr); // only a flagged read counts as a load
    end
  end

  function automatic word_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic word_t fill_word(input int idx);
    word_t addr;
    addr = word_t'(idx) << 2;
    return {~addr[15:0], addr[15:0]} ^ 32'h3c5a_0000; // every address bit shows up
  endfunction

  function automatic word_t sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // one instruction encoder per format
  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input opcode_t opc, input reg_addr_t rd, input funct3_t f3,
                                   input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input reg_addr_t rs2, input reg_addr_t rs1,
                                   input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t b_type(input funct3_t f3, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t u_type(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, OPC_LUI};
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_word(input string test, input string what, input word_t expected,
                            input word_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %08h actual %08h", test, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic check_reg_addr(input string test, input string what,
                                input reg_addr_t expected, input reg_addr_t actual);
    if (actual !== expected) begin
      $display("ERROR %s: %s expected %0d actual %0d", test, what, expected, actual);
      stop_on_failure();
    end
  endtask

  task automatic clear_program();
    prog.delete();
    exp_pc.delete();
    exp_inst.delete();
    exp_wdata.delete();
    exp_waddr.delete();
    exp_has_data.delete();
  endtask

  // an instruction that must retire with the given destination and value
  task automatic add_inst(input word_t inst, input reg_addr_t waddr, input word_t wdata,
                          input bit has_data);
    exp_pc.push_back(word_t'(prog.size()) << 2);
    exp_inst.push_back(inst);
    exp_waddr.push_back(waddr);
    exp_wdata.push_back(wdata);
    exp_has_data.push_back(has_data);
    prog.push_back(inst);
  endtask

  task automatic skip_inst(input word_t inst); // sits in a squashed slot
    prog.push_back(inst);
  endtask

  // lui plus addi with the upper part corrected for the sign of the low part
  task automatic load_const(input reg_addr_t rd, input word_t value);
    word_t upper;
    upper = value - sext12(value[11:0]);
    add_inst(u_type(rd, upper[31:12]), rd, upper, 1'b1);
    add_inst(i_type(OPC_OP_IMM, rd, F3_ADD_SUB, rd, value[11:0]), rd, value, 1'b1);
  endtask

  task automatic reset_and_load();
    word_t addr;
    @(posedge clk);
    #1 rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      addr = word_t'(i) << 2;
      // unused words are nops whose immediate is the address itself
      imem[i] = (i < prog.size()) ? prog[i] :
                i_type(OPC_OP_IMM, 5'd0, F3_ADD_SUB, 5'd0, addr[11:0]);
    end
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic run_program(input string test);
    int cycles;
    int idx;
    bit halted;
    reset_and_load();
    cycles = 0;
    idx    = 0;
    halted = 1'b0;
    while (!halted) begin
      @(negedge clk); // retire outputs are settled half a cycle after the edge
      if (retire_valid) begin
        if (idx >= exp_pc.size()) begin
          $display("%s: more instructions retired than the program holds", test);
          stop_on_failure();
        end
        check_word(test, "retire pc", exp_pc[idx], retire_pc);
        check_word(test, "retire inst", exp_inst[idx], retire_inst);
        check_reg_addr(test, "retire rd", exp_waddr[idx], retire_rd_waddr);
        if (exp_has_data[idx]) check_word(test, "retire data", exp_wdata[idx], retire_rd_wdata);
        halted = retire_halt;
        idx++;
      end
      cycles++;
      if (!halted && cycles > HALT_TIMEOUT) begin
        $display("%s: the halt never came within %0d cycles", test, HALT_TIMEOUT);
        stop_on_failure();
      end
    end
    if (idx != exp_pc.size()) begin
      $display("%s: halt retired after only %0d of %0d instructions", test, idx, exp_pc.size());
      stop_on_failure();
    end
  endtask

  task automatic alu_ops();
    word_t a, b, r, si;
    logic [11:0] imm;
    a   = next_rand();
    b   = next_rand();
    r   = next_rand();
    imm = r[11:0];
    si  = sext12(imm);
    clear_program();
    load_const(5'd1, a); // each addi waits for its own lui
    load_const(5'd2, b);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_ADD_SUB, 5'd3), 5'd3, a + b, 1'b1);
    add_inst(r_type(7'h20, 5'd2, 5'd1, F3_ADD_SUB, 5'd4), 5'd4, a - b, 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_AND, 5'd5), 5'd5, a & b, 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_OR, 5'd6), 5'd6, a | b, 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_XOR, 5'd7), 5'd7, a ^ b, 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_SLT, 5'd8), 5'd8,
             ($signed(a) < $signed(b)) ? 32'd1 : 32'd0, 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_SLL, 5'd9), 5'd9, a << b[4:0], 1'b1);
    add_inst(r_type(7'h00, 5'd2, 5'd1, F3_SRL, 5'd10), 5'd10, a >> b[4:0], 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd11, F3_ADD_SUB, 5'd1, imm), 5'd11, a + si, 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd12, F3_AND, 5'd1, imm), 5'd12, a & si, 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd13, F3_OR, 5'd1, imm), 5'd13, a | si, 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd14, F3_XOR, 5'd1, imm), 5'd14, a ^ si, 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd15, F3_SLT, 5'd1, imm), 5'd15,
             ($signed(a) < $signed(si)) ? 32'd1 : 32'd0, 1'b1);
    add_inst(EBREAK_INST, 5'd0, '0, 1'b0);
    run_program("alu_ops");
  endtask

  task automatic upper_immediates();
    word_t v;
    clear_program();
    for (int k = 0; k < 4; k++) begin
      v = next_rand();
      add_inst(u_type(reg_addr_t'(20 + k), v[31:12]), reg_addr_t'(20 + k),
               {v[31:12], 12'h000}, 1'b1);
    end
    add_inst(EBREAK_INST, 5'd0, '0, 1'b0);
    run_program("upper_immediates");
  endtask

  task automatic load_store_words();
    word_t val [3];
    logic [11:0] off [3];
    word_t r;
    clear_program();
    for (int k = 0; k < 3; k++) begin
      val[k] = next_rand();
      r      = next_rand();
      off[k] = 12'h200 + 12'(k * 16) + {8'd0, r[1:0], 2'b00}; // distinct words
      load_const(reg_addr_t'(5 + k), val[k]);
      add_inst(s_type(reg_addr_t'(5 + k), 5'd0, off[k]), 5'd0, '0, 1'b0);
    end
    for (int k = 0; k < 3; k++) begin
      add_inst(i_type(OPC_LOAD, reg_addr_t'(10 + k), F3_WORD, 5'd0, off[k]),
               reg_addr_t'(10 + k), val[k], 1'b1);
    end
    add_inst(EBREAK_INST, 5'd0, '0, 1'b0);
    run_program("load_store_words");
    check_word("load_store_words", "store count", 32'd3, word_t'(store_addr_q.size()));
    check_word("load_store_words", "load count", 32'd3, word_t'(load_addr_q.size()));
    for (int k = 0; k < 3; k++) begin
      check_word("load_store_words", "store addr", sext12(off[k]), store_addr_q[k]);
      check_word("load_store_words", "store data", val[k], store_data_q[k]);
      check_word("load_store_words", "load addr", sext12(off[k]), load_addr_q[k]);
    end
  endtask

  task automatic branch_squash();
    word_t v;
    v = next_rand();
    clear_program();
    add_inst(i_type(OPC_OP_IMM, 5'd1, F3_ADD_SUB, 5'd0, v[11:0]), 5'd1, sext12(v[11:0]), 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd2, F3_ADD_SUB, 5'd0, v[11:0]), 5'd2, sext12(v[11:0]), 1'b1);
    add_inst(b_type(F3_BEQ, 5'd1, 5'd2, 13'd12), 5'd0, '0, 1'b0); // taken so it lands on the bne
    skip_inst(i_type(OPC_OP_IMM, 5'd3, F3_ADD_SUB, 5'd0, 12'd1));
    skip_inst(i_type(OPC_OP_IMM, 5'd4, F3_ADD_SUB, 5'd0, 12'd2));
    add_inst(b_type(F3_BNE, 5'd1, 5'd2, 13'd8), 5'd0, '0, 1'b0); // equal operands fall through
    add_inst(i_type(OPC_OP_IMM, 5'd5, F3_ADD_SUB, 5'd0, 12'd3), 5'd5, 32'd3, 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd6, F3_ADD_SUB, 5'd0, 12'd4), 5'd6, 32'd4, 1'b1);
    add_inst(EBREAK_INST, 5'd0, '0, 1'b0);
    run_program("branch_squash");
  endtask

  task automatic halt_and_x0();
    word_t v;
    v = next_rand();
    clear_program();
    add_inst(i_type(OPC_OP_IMM, 5'd1, F3_ADD_SUB, 5'd0, v[11:0]), 5'd1, sext12(v[11:0]), 1'b1);
    add_inst(i_type(OPC_OP_IMM, 5'd0, F3_ADD_SUB, 5'd1, v[23:12]), 5'd0, '0, 1'b0);
    add_inst(r_type(7'h00, 5'd1, 5'd1, F3_ADD_SUB, 5'd0), 5'd0, '0, 1'b0);
    add_inst(u_type(5'd0, v[31:12]), 5'd0, '0, 1'b0);
    // x0 must still read zero after three attempted writes
    add_inst(r_type(7'h00, 5'd1, 5'd0, F3_ADD_SUB, 5'd2), 5'd2, sext12(v[11:0]), 1'b1);
    add_inst(EBREAK_INST, 5'd0, '0, 1'b0);
    run_program("halt_and_x0");
  endtask

  initial begin
    lcg_state = 32'h0db91ff7;
    alu_ops();
    upper_immediates();
    load_store_words();
    branch_squash();
    halt_and_x0();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== verification/hart_props.sv ====
`timescale 1ns/100ps

module hart_props (
  input logic            i_clk,
  input logic            i_rst,
  input hart_pkg::word_t i_imem_raddr,
  input logic            i_dmem_ren,
  input logic            i_dmem_wen,
  input logic            i_retire_valid
);

  // one memory access per instruction, never a read and a write together
  a_dmem_exclusive: assert property (@(posedge i_clk) disable iff (i_rst)
    !(i_dmem_ren && i_dmem_wen))
    else $error("dmem read and write enables are high together");

  // an edge with reset held leaves the outputs quiet in the next cycle
  a_reset_quiet: assert property (@(posedge i_clk)
    i_rst |=> !(i_retire_valid || i_dmem_ren || i_dmem_wen))
    else $error("retire or dmem enable is high right after a reset edge");

  a_fetch_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
    i_imem_raddr[1:0] == 2'b00)
    else $error("instruction fetch address is not word aligned");

endmodule

bind hart hart_props u_hart_props (
  .i_clk(i_clk), .i_rst(i_rst), .i_imem_raddr(o_imem_raddr),
  .i_dmem_ren(o_dmem_ren), .i_dmem_wen(o_dmem_wen), .i_retire_valid(o_retire_valid)
);

// ==== hdl/hart.sv ====
`timescale 1ns/100ps

module hart (
  input  logic               i_clk,
  input  logic               i_rst,
  output hart_pkg::word_t    o_imem_raddr,
  input  hart_pkg::word_t    i_imem_rdata,
  output hart_pkg::word_t    o_dmem_addr,
  output hart_pkg::word_t    o_dmem_wdata,
  output logic               o_dmem_ren,
  output logic               o_dmem_wen,
  input  hart_pkg::word_t    i_dmem_rdata,
  output logic               o_retire_valid,
  output logic               o_retire_halt,
  output hart_pkg::word_t    o_retire_inst,
  output hart_pkg::word_t    o_retire_pc,
  output hart_pkg::word_t    o_retire_rd_wdata,
  output hart_pkg::reg_addr_t o_retire_rd_waddr
);
  import hart_pkg::*;

  // decode stage, out of the IF/ID register
  word_t     id_inst, id_pc;
  logic      id_valid;
  word_t     rs1_rdata, rs2_rdata;

  // control word and hazard status from the decoder
  logic      stall;
  alu_op_t   alu_op;
  word_t     imm;
  logic      use_imm, reg_wen, mem_read, mem_write, branch, branch_ne;
  reg_addr_t rd;

  // execute stage results heading into EX/MEM
  logic      redirect;
  word_t     target;
  reg_addr_t ex_rd, mem_rd, wb_waddr;
  logic      ex_wen, mem_wen, wb_wen;
  word_t     ex_alu_result, ex_store_data, ex_inst, ex_pc;
  logic      ex_valid, ex_mem_read, ex_mem_write;
  word_t     wb_wdata;

  pipe_control u_pipe_control (
    .i_id_inst(id_inst), .i_id_valid(id_valid),
    .i_ex_rd(ex_rd),     .i_ex_wen(ex_wen),
    .i_mem_rd(mem_rd),   .i_mem_wen(mem_wen),
    .o_stall(stall),     .o_alu_op(alu_op), .o_imm(imm), .o_use_imm(use_imm),
    .o_reg_wen(reg_wen), .o_mem_read(mem_read), .o_mem_write(mem_write),
    .o_branch(branch),   .o_branch_ne(branch_ne), .o_rd(rd)
  );

  fetch_stage u_fetch_stage (
    .i_clk(i_clk), .i_rst(i_rst), .i_stall(stall),
    .i_redirect(redirect), .i_target(target), .i_imem_rdata(i_imem_rdata),
    .o_imem_raddr(o_imem_raddr), .o_id_inst(id_inst), .o_id_pc(id_pc),
    .o_id_valid(id_valid)
  );

  reg_file u_reg_file (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_rs1_raddr(id_inst[19:15]), .i_rs2_raddr(id_inst[24:20]),
    .i_rd_waddr(wb_waddr), .i_rd_wen(wb_wen), .i_rd_wdata(wb_wdata),
    .o_rs1_rdata(rs1_rdata), .o_rs2_rdata(rs2_rdata)
  );

  execute_stage u_execute_stage (
    .i_clk(i_clk), .i_rst(i_rst), .i_stall(stall),
    .i_id_pc(id_pc), .i_id_inst(id_inst), .i_id_valid(id_valid),
    .i_rs1_rdata(rs1_rdata), .i_rs2_rdata(rs2_rdata),
    .i_alu_op(alu_op), .i_imm(imm), .i_use_imm(use_imm), .i_reg_wen(reg_wen),
    .i_mem_read(mem_read), .i_mem_write(mem_write),
    .i_branch(branch), .i_branch_ne(branch_ne), .i_rd(rd),
    .o_redirect(redirect), .o_target(target), .o_ex_rd(ex_rd), .o_ex_wen(ex_wen),
    .o_alu_result(ex_alu_result), .o_store_data(ex_store_data),
    .o_inst(ex_inst), .o_pc(ex_pc), .o_valid(ex_valid),
    .o_mem_read(ex_mem_read), .o_mem_write(ex_mem_write)
  );

  mem_wb_stage u_mem_wb_stage (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_valid(ex_valid), .i_inst(ex_inst), .i_pc(ex_pc),
    .i_alu_result(ex_alu_result), .i_store_data(ex_store_data),
    .i_mem_read(ex_mem_read), .i_mem_write(ex_mem_write),
    .i_rd(ex_rd), .i_reg_wen(ex_wen), .i_dmem_rdata(i_dmem_rdata),
    .o_dmem_addr(o_dmem_addr), .o_dmem_ren(o_dmem_ren),
    .o_dmem_wen(o_dmem_wen), .o_dmem_wdata(o_dmem_wdata),
    .o_mem_rd(mem_rd), .o_mem_wen(mem_wen),
    .o_wb_waddr(wb_waddr), .o_wb_wen(wb_wen), .o_wb_wdata(wb_wdata),
    .o_retire_valid(o_retire_valid), .o_retire_halt(o_retire_halt),
    .o_retire_inst(o_retire_inst), .o_retire_pc(o_retire_pc),
    .o_retire_rd_waddr(o_retire_rd_waddr), .o_retire_rd_wdata(o_retire_rd_wdata)
  );

endmodule

// ==== hdl/mem_wb_stage.sv ====
`timescale 1ns/100ps

module mem_wb_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_valid,
  input  hart_pkg::word_t     i_inst,
  input  hart_pkg::word_t     i_pc,
  input  hart_pkg::word_t     i_alu_result,
  input  hart_pkg::word_t     i_store_data,
  input  logic                i_mem_read,
  input  logic                i_mem_write,
  input  hart_pkg::reg_addr_t i_rd,
  input  logic                i_reg_wen,
  input  hart_pkg::word_t     i_dmem_rdata,
  output hart_pkg::word_t     o_dmem_addr,
  output logic                o_dmem_ren,
  output logic                o_dmem_wen,
  output hart_pkg::word_t     o_dmem_wdata,
  output hart_pkg::reg_addr_t o_mem_rd,
  output logic                o_mem_wen,
  output hart_pkg::reg_addr_t o_wb_waddr,
  output logic                o_wb_wen,
  output hart_pkg::word_t     o_wb_wdata,
  output logic                o_retire_valid,
  output logic                o_retire_halt,
  output hart_pkg::word_t     o_retire_inst,
  output hart_pkg::word_t     o_retire_pc,
  output hart_pkg::reg_addr_t o_retire_rd_waddr,
  output hart_pkg::word_t     o_retire_rd_wdata
);
  import hart_pkg::*;

  logic      mem_valid, wb_is_load;
  word_t     mem_inst, mem_pc;
  word_t     wb_alu, wb_load;
  reg_addr_t wb_rd;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mem_valid      <= 1'b0;
      o_dmem_ren     <= 1'b0;
      o_dmem_wen     <= 1'b0;
      o_mem_wen      <= 1'b0;
      mem_inst       <= NOP_INST;
      o_retire_valid <= 1'b0;
      o_wb_wen       <= 1'b0;
      wb_is_load     <= 1'b0;
      o_retire_inst  <= NOP_INST;
    end else begin
      mem_valid      <= i_valid;        // EX/MEM
      o_dmem_ren     <= i_mem_read;
      o_dmem_wen     <= i_mem_write;
      o_mem_wen      <= i_reg_wen;
      mem_inst       <= i_inst;
      o_retire_valid <= mem_valid;      // MEM/WB
      o_wb_wen       <= o_mem_wen;
      wb_is_load     <= o_dmem_ren;
      o_retire_inst  <= mem_inst;
    end
  end

  always_ff @(posedge i_clk) begin
    o_dmem_addr  <= i_alu_result;
    o_dmem_wdata <= i_store_data;
    o_mem_rd     <= i_rd;
    mem_pc       <= i_pc;
    wb_alu       <= o_dmem_addr;    // the ALU result rides along as the address
    wb_load      <= i_dmem_rdata;   // load word captured as it comes back
    wb_rd        <= o_mem_rd;
    o_retire_pc  <= mem_pc;
  end

  // instructions that write nothing report x0 as their destination
  assign o_wb_waddr = o_wb_wen ? wb_rd : 5'd0;
  assign o_wb_wdata = wb_is_load ? wb_load : wb_alu;

  assign o_retire_halt     = o_retire_valid && (o_retire_inst == EBREAK_INST);
  assign o_retire_rd_waddr = o_wb_waddr;
  assign o_retire_rd_wdata = o_wb_wdata;

endmodule

// ==== hdl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_stall,
  input  hart_pkg::word_t     i_id_pc,
  input  hart_pkg::word_t     i_id_inst,
  input  logic                i_id_valid,
  input  hart_pkg::word_t     i_rs1_rdata,
  input  hart_pkg::word_t     i_rs2_rdata,
  input  hart_pkg::alu_op_t   i_alu_op,
  input  hart_pkg::word_t     i_imm,
  input  logic                i_use_imm,
  input  logic                i_reg_wen,
  input  logic                i_mem_read,
  input  logic                i_mem_write,
  input  logic                i_branch,
  input  logic                i_branch_ne,
  input  hart_pkg::reg_addr_t i_rd,
  output logic                o_redirect,
  output hart_pkg::word_t     o_target,
  output hart_pkg::reg_addr_t o_ex_rd,
  output logic                o_ex_wen,
  output hart_pkg::word_t     o_alu_result,
  output hart_pkg::word_t     o_store_data,
  output hart_pkg::word_t     o_inst,
  output hart_pkg::word_t     o_pc,
  output logic                o_valid,
  output logic                o_mem_read,
  output logic                o_mem_write
);
  import hart_pkg::*;

  logic    bubble;
  logic    ex_branch, ex_branch_ne, ex_use_imm;
  alu_op_t ex_alu_op;
  word_t   ex_rs1, ex_rs2, ex_imm, op_b;

  // a stalled decode or a squashed younger slot both enter as a bubble
  assign bubble = i_stall || o_redirect;

  always_ff @(posedge i_clk) begin
    if (i_rst || bubble) begin
      o_valid      <= 1'b0;
      o_ex_wen     <= 1'b0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      ex_branch    <= 1'b0;
      ex_branch_ne <= 1'b0;
      o_inst       <= NOP_INST;
    end else begin
      o_valid      <= i_id_valid;
      o_ex_wen     <= i_reg_wen; // decoder already clears this for invalid slots
      o_mem_read   <= i_mem_read;
      o_mem_write  <= i_mem_write;
      ex_branch    <= i_branch;
      ex_branch_ne <= i_branch_ne;
      o_inst       <= i_id_inst;
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc       <= i_id_pc;
    o_ex_rd    <= i_rd;
    ex_rs1     <= i_rs1_rdata;
    ex_rs2     <= i_rs2_rdata;
    ex_imm     <= i_imm;
    ex_alu_op  <= i_alu_op;
    ex_use_imm <= i_use_imm;
  end

  assign op_b         = ex_use_imm ? ex_imm : ex_rs2;
  assign o_store_data = ex_rs2; // sw data comes straight from rs2

  always_comb begin
    case (ex_alu_op)
      ALU_ADD:    o_alu_result = ex_rs1 + op_b;
      ALU_SUB:    o_alu_result = ex_rs1 - op_b;
      ALU_AND:    o_alu_result = ex_rs1 & op_b;
      ALU_OR:     o_alu_result = ex_rs1 | op_b;
      ALU_XOR:    o_alu_result = ex_rs1 ^ op_b;
      ALU_SLT:    o_alu_result = {31'd0, $signed(ex_rs1) < $signed(op_b)};
      ALU_SLL:    o_alu_result = ex_rs1 << op_b[4:0];
      ALU_SRL:    o_alu_result = ex_rs1 >> op_b[4:0];
      ALU_PASS_B: o_alu_result = op_b;
      default:    o_alu_result = '0;
    endcase
  end

  // beq takes on equal operands, bne on unequal
  assign o_redirect = ex_branch && ((ex_rs1 == ex_rs2) != ex_branch_ne);
  assign o_target   = o_pc + ex_imm;

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
  input  logic                i_clk,
  input  logic                i_rst,
  input  hart_pkg::reg_addr_t i_rs1_raddr,
  input  hart_pkg::reg_addr_t i_rs2_raddr,
  input  hart_pkg::reg_addr_t i_rd_waddr,
  input  logic                i_rd_wen,
  input  hart_pkg::word_t     i_rd_wdata,
  output hart_pkg::word_t     o_rs1_rdata,
  output hart_pkg::word_t     o_rs2_rdata
);
  import hart_pkg::*;

  word_t regs [32]; // entry 0 is never written

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else if (i_rd_wen && i_rd_waddr != 5'd0) begin
      regs[i_rd_waddr] <= i_rd_wdata;
    end
  end

  // a write in this cycle is seen by decode, which closes the writeback hazard
  assign o_rs1_rdata = (i_rs1_raddr == 5'd0) ? '0 :
                       (i_rd_wen && i_rd_waddr == i_rs1_raddr) ? i_rd_wdata : regs[i_rs1_raddr];
  assign o_rs2_rdata = (i_rs2_raddr == 5'd0) ? '0 :
                       (i_rd_wen && i_rd_waddr == i_rs2_raddr) ? i_rd_wdata : regs[i_rs2_raddr];

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_stall,
  input  logic            i_redirect,
  input  hart_pkg::word_t i_target,
  input  hart_pkg::word_t i_imem_rdata,
  output hart_pkg::word_t o_imem_raddr,
  output hart_pkg::word_t o_id_inst,
  output hart_pkg::word_t o_id_pc,
  output logic            o_id_valid
);
  import hart_pkg::*;

  word_t pc_q;

  assign o_imem_raddr = pc_q; // imem answers in the same cycle

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q       <= RESET_ADDR;
      o_id_valid <= 1'b0;
      o_id_inst  <= NOP_INST;
    end else if (i_redirect) begin // a taken branch beats a stall
      pc_q       <= i_target;
      o_id_valid <= 1'b0;          // squash the wrong-path fetch
      o_id_inst  <= NOP_INST;
    end else if (!i_stall) begin
      pc_q       <= pc_q + 32'd4;
      o_id_valid <= 1'b1;
      o_id_inst  <= i_imem_rdata;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) o_id_pc <= pc_q; // only meaningful while o_id_valid is high
  end

endmodule

// ==== hdl/pipe_control.sv ====
`timescale 1ns/100ps

module pipe_control (
  input  hart_pkg::word_t     i_id_inst,
  input  logic                i_id_valid,
  input  hart_pkg::reg_addr_t i_ex_rd,
  input  logic                i_ex_wen,
  input  hart_pkg::reg_addr_t i_mem_rd,
  input  logic                i_mem_wen,
  output logic                o_stall,
  output hart_pkg::alu_op_t   o_alu_op,
  output hart_pkg::word_t     o_imm,
  output logic                o_use_imm,
  output logic                o_reg_wen,
  output logic                o_mem_read,
  output logic                o_mem_write,
  output logic                o_branch,
  output logic                o_branch_ne,
  output hart_pkg::reg_addr_t o_rd
);
  import hart_pkg::*;

  opcode_t   opcode;
  funct3_t   funct3;
  reg_addr_t rs1, rs2;
  word_t     imm_i, imm_s, imm_b, imm_u;
  logic      use_rs1, use_rs2;   // which source fields really name a register
  logic      rs1_hit, rs2_hit;

  assign opcode = i_id_inst[6:0];
  assign funct3 = i_id_inst[14:12];
  assign rs1    = i_id_inst[19:15];
  assign rs2    = i_id_inst[24:20];
  assign o_rd   = i_id_inst[11:7];

  // every immediate format except U is sign-extended from inst[31]
  assign imm_i = {{20{i_id_inst[31]}}, i_id_inst[31:20]};
  assign imm_s = {{20{i_id_inst[31]}}, i_id_inst[31:25], i_id_inst[11:7]};
  assign imm_b = {{19{i_id_inst[31]}}, i_id_inst[31], i_id_inst[7],
                  i_id_inst[30:25], i_id_inst[11:8], 1'b0};
  assign imm_u = {i_id_inst[31:12], 12'h000};

  always_comb begin
    o_alu_op    = ALU_ADD; // address adds for loads and stores use this default
    o_imm       = imm_i;
    o_use_imm   = 1'b0;
    o_reg_wen   = 1'b0;
    o_mem_read  = 1'b0;
    o_mem_write = 1'b0;
    o_branch    = 1'b0;
    o_branch_ne = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    if (i_id_valid) begin
      case (opcode)
        OPC_OP: begin
          use_rs1   = 1'b1;
          use_rs2   = 1'b1;
          o_reg_wen = 1'b1;
          case (funct3)
            F3_ADD_SUB: o_alu_op = i_id_inst[30] ? ALU_SUB : ALU_ADD;
            F3_SLL:     o_alu_op = ALU_SLL;
            F3_SLT:     o_alu_op = ALU_SLT;
            F3_XOR:     o_alu_op = ALU_XOR;
            F3_SRL:     o_alu_op = ALU_SRL;
            F3_OR:      o_alu_op = ALU_OR;
            F3_AND:     o_alu_op = ALU_AND;
            default:    o_reg_wen = 1'b0; // sltu is not part of the subset
          endcase
        end
        OPC_OP_IMM: begin
          use_rs1   = 1'b1;
          o_use_imm = 1'b1;
          o_reg_wen = 1'b1;
          case (funct3)
            F3_ADD_SUB: o_alu_op = ALU_ADD;
            F3_SLT:     o_alu_op = ALU_SLT;
            F3_XOR:     o_alu_op = ALU_XOR;
            F3_OR:      o_alu_op = ALU_OR;
            F3_AND:     o_alu_op = ALU_AND;
            default:    o_reg_wen = 1'b0; // immediate shifts retire as a nop
          endcase
        end
        OPC_LUI: begin
          o_imm     = imm_u;
          o_use_imm = 1'b1;
          o_alu_op  = ALU_PASS_B;
          o_reg_wen = 1'b1;
        end
        OPC_LOAD: begin
          use_rs1    = (funct3 == F3_WORD);
          o_use_imm  = 1'b1;
          o_mem_read = (funct3 == F3_WORD); // byte and half loads do nothing
          o_reg_wen  = (funct3 == F3_WORD);
        end
        OPC_STORE: begin
          use_rs1     = (funct3 == F3_WORD);
          use_rs2     = (funct3 == F3_WORD);
          o_imm       = imm_s;
          o_use_imm   = 1'b1;
          o_mem_write = (funct3 == F3_WORD);
        end
        OPC_BRANCH: begin
          o_imm       = imm_b;
          o_branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
          o_branch_ne = (funct3 == F3_BNE);
          use_rs1     = o_branch;
          use_rs2     = o_branch;
        end
        default:    o_reg_wen = 1'b0; // ebreak flows as a nop and writeback flags the halt
      endcase
    end
  end

  // no forwarding, so wait until the producer reaches writeback
  assign rs1_hit = (rs1 != 5'd0) &&
                   ((i_ex_wen && rs1 == i_ex_rd) || (i_mem_wen && rs1 == i_mem_rd));
  assign rs2_hit = (rs2 != 5'd0) &&
                   ((i_ex_wen && rs2 == i_ex_rd) || (i_mem_wen && rs2 == i_mem_rd));

  assign o_stall = (use_rs1 && rs1_hit) || (use_rs2 && rs2_hit);

endmodule

// ==== hdl/hart_pkg.sv ====
package hart_pkg;

  typedef logic [31:0] word_t;     // data, address and instruction words
  typedef logic [4:0]  reg_addr_t; // architectural register index
  typedef logic [3:0]  alu_op_t;   // ALU operation select
  typedef logic [6:0]  opcode_t;   // major opcode, inst[6:0]
  typedef logic [2:0]  funct3_t;   // minor function field, inst[14:12]

  // major opcodes of the supported subset
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;
  localparam opcode_t OPC_BRANCH = 7'b1100011;
  localparam opcode_t OPC_SYSTEM = 7'b1110011; // only ebreak is expected here

  // funct3 values for the integer operations
  localparam funct3_t F3_ADD_SUB = 3'b000; // inst[30] picks sub for register ops
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL     = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_WORD    = 3'b010; // lw and sw, the only widths kept
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  // ALU operation codes, decoded once in the control module
  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLL    = 4'd6;
  localparam alu_op_t ALU_SRL    = 4'd7;
  localparam alu_op_t ALU_PASS_B = 4'd8; // lui passes the upper immediate through

  localparam word_t RESET_ADDR  = 32'h0000_0000; // first fetch after reset
  localparam word_t NOP_INST    = 32'h0000_0013; // addi x0, x0, 0 fills bubbles
  localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage
